// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --timing --assert --timescale 1ns/100ps
TOP       := tb_rv_core
FILELIST  := build.f
OBJ_DIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
src/rv_pkg.sv
src/instr_mem.sv
src/fetch_unit.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/rv_core_top.sv
sim/rv_core_assertions.sv
sim/tb_rv_core.sv

// File: sim/rv_core_assertions.sv
`default_nettype none

module rv_core_assertions
    import rv_pkg::*;
(
    input wire logic sys_clk_i,
    input wire logic rst_n_i,
    input wire logic run_i,
    input wire logic load_req_i,
    input wire logic load_ack_o,
    input wire wb_t  wb_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------------------------------------------------
    // load handshake
    // ------------------------------------------------------------------------
    ack_rise_granted: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        $rose(load_ack_o) |-> $past(load_req_i && !run_i))
        else $error("load ack raised without a granted request");

    ack_fall_after_req: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        $fell(load_ack_o) |-> !$past(load_req_i))
        else $error("load ack dropped while request still high");

    ack_held: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        load_ack_o && load_req_i |=> load_ack_o)
        else $error("load ack not held until request drops");

    // reset leaves no ack and no write-back
    reset_quiet: assert property (@(posedge sys_clk_i)
        !rst_n_i |=> !load_ack_o && !wb_o.wr_en)
        else $error("ack or write-back active right after reset");

endmodule

`default_nettype wire

// File: sim/tb_rv_core.sv
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 200;   // cycles per wait

    logic  sys_clk_i;
    logic  rst_n_i;
    logic  run_i;
    logic  load_req_i;
    load_t load_i;
    logic  load_ack_o;
    wb_t   wb_o;

    logic [XLEN-1:0] ref_regs [32];   // reference register model
    logic [XLEN-1:0] prog [$];
    logic [4:0]      exp_rd [$];
    logic [XLEN-1:0] exp_data [$];
    integer          seed;
    int              errors;
    int              tests;
    int              test_start;
    string           cur_test;

    rv_core_top rv_core_top_i (
        .sys_clk_i  (sys_clk_i),
        .rst_n_i    (rst_n_i),
        .run_i      (run_i),
        .load_req_i (load_req_i),
        .load_i     (load_i),
        .load_ack_o (load_ack_o),
        .wb_o       (wb_o)
    );

    bind rv_core_top rv_core_assertions rv_core_assertions_i (
        .sys_clk_i  (sys_clk_i),
        .rst_n_i    (rst_n_i),
        .run_i      (run_i),
        .load_req_i (load_req_i),
        .load_ack_o (load_ack_o),
        .wb_o       (wb_o)
    );

    initial begin
        sys_clk_i = 1'b0;
        forever #2 sys_clk_i = ~sys_clk_i;
    end

    // ------------------------------------------------------------------------
    // encoders and reference model
    // ------------------------------------------------------------------------
    function automatic logic [XLEN-1:0] enc_i(
        input logic [2:0]  f3,
        input logic [4:0]  rd,
        input logic [4:0]  rs1,
        input logic [11:0] imm
    );
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [XLEN-1:0] enc_r(
        input logic [6:0] f7,
        input logic [4:0] rd,
        input logic [4:0] rs1,
        input logic [4:0] rs2
    );
        return {f7, rs2, rs1, F3_ADD_SUB, rd, OPC_OP};
    endfunction

    // queue the expected write-back and update the model
    task automatic expect_insn(input logic [XLEN-1:0] w);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic [4:0]      rd;
        a  = ref_regs[w[19:15]];
        rd = w[11:7];
        if (w[6:0] == OPC_OP_IMM) begin
            b = {{20{w[31]}}, w[31:20]};
        end else if (w[6:0] == OPC_OP) begin
            b = ref_regs[w[24:20]];
        end else begin
            return;                      // no write-back for other opcodes
        end
        case (w[14:12])
            F3_ADD_SUB: res = (w[6:0] == OPC_OP && w[30]) ? a - b : a + b;
            F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    res = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     res = a ^ b;
            F3_OR:      res = a | b;
            F3_AND:     res = a & b;
            F3_SLL:     res = a << b[4:0];
            default:    res = '0;
        endcase
        exp_rd.push_back(rd);
        exp_data.push_back(res);
        if (rd != 5'd0) begin
            ref_regs[rd] = res;
        end
    endtask

    task automatic add_insn(input logic [XLEN-1:0] w);
        prog.push_back(w);
        expect_insn(w);
    endtask

    // ------------------------------------------------------------------------
    // bus helpers
    // ------------------------------------------------------------------------
    task automatic abort(input string what);
        $display("Timeout: no %s within %0d cycles in %s", what, TIMEOUT, cur_test);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        @(negedge sys_clk_i);
        while (load_ack_o !== level && n < TIMEOUT) begin
            n++;
            @(negedge sys_clk_i);
        end
        if (load_ack_o !== level) begin
            abort("load ack change");
        end
    endtask

    task automatic load_word(input logic [IMEM_ADDR_W-1:0] idx, input logic [XLEN-1:0] w);
        @(posedge sys_clk_i);
        load_i.idx  <= idx;
        load_i.word <= w;
        load_req_i  <= 1'b1;
        wait_ack(1'b1);
        @(posedge sys_clk_i);
        load_req_i <= 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic check_wb(input logic [4:0] rd, input logic [XLEN-1:0] data);
        if (wb_o.rd !== rd) begin
            $display("Error: %s rd expected %0d actual %0d", cur_test, rd, wb_o.rd);
            errors++;
        end
        if (wb_o.data !== data) begin
            $display("Error: %s data expected %h actual %h", cur_test, data, wb_o.data);
            errors++;
        end
    endtask

    // run the core until every expected write-back is seen
    task automatic run_collect();
        int n;
        n = 0;
        @(posedge sys_clk_i);
        run_i <= 1'b1;
        while (exp_rd.size() > 0 && n < TIMEOUT) begin
            @(negedge sys_clk_i);
            if (wb_o.wr_en) begin
                check_wb(exp_rd.pop_front(), exp_data.pop_front());
            end else begin
                n++;
            end
        end
        if (exp_rd.size() > 0) begin
            abort("write-back");
        end else begin
            @(posedge sys_clk_i);
            run_i <= 1'b0;
            repeat (4) begin               // words past the program write nothing
                @(negedge sys_clk_i);
                if (wb_o.wr_en) begin
                    $display("Error: %s has a write-back after its last instruction",
                             cur_test);
                    errors++;
                end
            end
        end
    endtask

    task automatic exec_program();
        for (int i = 0; i < prog.size(); i++) begin
            load_word(IMEM_ADDR_W'(i), prog[i]);
        end
        run_collect();
        for (int i = 0; i < prog.size(); i++) begin
            load_word(IMEM_ADDR_W'(i), '0);   // clean memory for the next test
        end
        prog.delete();
    endtask

    task automatic begin_test(input string name);
        cur_test   = name;
        test_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("%s finished, %0d errors", cur_test, errors - test_start);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset();
        begin_test("reset_state");
        repeat (6) begin
            @(negedge sys_clk_i);
            if (load_ack_o !== 1'b0 || wb_o.wr_en !== 1'b0) begin
                $display("Error: %s ack,wr_en expected 00 actual %b%b",
                         cur_test, load_ack_o, wb_o.wr_en);
                errors++;
            end
        end
        end_test();
    endtask

    task automatic test_itype();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  rd;
        begin_test("itype_alu");
        for (int i = 1; i < 32; i++) begin   // every register gets a random value first
            r = $random(seed);
            add_insn(enc_i(F3_ADD_SUB, 5'(i), 5'd0, r[11:0]));
        end
        for (int i = 0; i < 14; i++) begin
            r = $random(seed);
            case (i % 7)
                0:       f3 = F3_ADD_SUB;
                1:       f3 = F3_SLT;
                2:       f3 = F3_SLTU;
                3:       f3 = F3_XOR;
                4:       f3 = F3_OR;
                5:       f3 = F3_AND;
                default: f3 = F3_SLL;
            endcase
            imm = (f3 == F3_SLL) ? {7'b0, r[24:20]} : r[31:20];   // slli keeps funct7 zero
            rd  = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
            add_insn(enc_i(f3, rd, r[9:5], imm));
        end
        exec_program();
        end_test();
    endtask

    task automatic test_rtype();
        begin_test("rtype_bypass");
        add_insn(enc_i(F3_ADD_SUB, 5'd1, 5'd0, 12'h123));
        add_insn(enc_i(F3_ADD_SUB, 5'd2, 5'd0, 12'hf9c));
        add_insn(enc_r(7'b0, 5'd6, 5'd1, 5'd2));     // each reads the one before
        add_insn(enc_r(F7_SUB, 5'd7, 5'd6, 5'd1));
        add_insn(enc_r(7'b0, 5'd8, 5'd7, 5'd6));
        add_insn(enc_r(F7_SUB, 5'd6, 5'd8, 5'd7));
        add_insn(enc_r(F7_SUB, 5'd10, 5'd0, 5'd6));
        exec_program();
        end_test();
    endtask

    task automatic test_x0();
        begin_test("x0_zero");
        add_insn(enc_i(F3_ADD_SUB, 5'd9, 5'd0, 12'd5));
        add_insn(enc_i(F3_ADD_SUB, 5'd0, 5'd0, 12'd77));   // shows on wb_o but is not stored
        add_insn(enc_r(7'b0, 5'd9, 5'd0, 5'd0));
        exec_program();
        end_test();
    endtask

    task automatic test_unsupported();
        begin_test("unsupported_skip");
        add_insn(enc_i(F3_ADD_SUB, 5'd1, 5'd1, 12'd5));
        add_insn(32'h0011_2023);                           // sw x1,0(x2)
        add_insn(enc_r(7'b0, 5'd2, 5'd1, 5'd1));
        add_insn(32'h0020_8463);                           // beq x1,x2,8
        add_insn(32'h1234_51b7);                           // lui x3,0x12345
        add_insn(enc_i(F3_XOR, 5'd4, 5'd2, 12'hfff));
        exec_program();
        end_test();
    endtask

    task automatic test_backpressure();
        logic [XLEN-1:0] w;
        begin_test("load_backpressure");
        w = enc_i(F3_ADD_SUB, 5'd5, 5'd0, 12'd123);
        @(posedge sys_clk_i);
        run_i <= 1'b1;
        @(posedge sys_clk_i);
        load_i.idx  <= '0;
        load_i.word <= w;
        load_req_i  <= 1'b1;
        repeat (12) begin
            @(negedge sys_clk_i);
            if (load_ack_o) begin
                $display("Error: %s got a load ack while the core was running", cur_test);
                errors++;
            end
        end
        @(posedge sys_clk_i);
        run_i <= 1'b0;
        wait_ack(1'b1);
        @(posedge sys_clk_i);
        load_req_i <= 1'b0;
        wait_ack(1'b0);
        expect_insn(w);
        run_collect();
        load_word('0, '0);
        end_test();
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        seed   = 32;
        errors = 0;
        tests  = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        rst_n_i    <= 1'b0;
        run_i      <= 1'b0;
        load_req_i <= 1'b0;
        load_i     <= '0;
        repeat (8) @(posedge sys_clk_i);
        rst_n_i <= 1'b1;

        test_reset();
        test_itype();
        test_rtype();
        test_x0();
        test_unsupported();
        test_backpressure();

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`default_nettype none

module decode_stage
    import rv_pkg::*;
(
    input  wire logic                  sys_clk_i,
    input  wire logic                  rst_n_i,
    input  wire fetch_t                fetch_i,
    // register file read
    output logic [REG_ADDR_W-1:0]      rs1_idx_o,
    output logic [REG_ADDR_W-1:0]      rs2_idx_o,
    input  wire logic [XLEN-1:0]       rs1_data_i,
    input  wire logic [XLEN-1:0]       rs2_data_i,
    // to execute
    output exec_t                      exec_o
);

    insn_u               insn;
    logic [ALU_OP_W-1:0] alu_op;
    logic                use_imm;     // op2 from imm12
    logic                supported;
    logic [XLEN-1:0]     imm_sext;
    exec_t               exec_d;
    exec_t               exec_r;

    assign insn     = fetch_i.insn;
    assign imm_sext = {{(XLEN-12){insn.i.imm12[11]}}, insn.i.imm12};

    // rs2 field is imm bits for I type, harmless read
    assign rs1_idx_o = insn.r.rs1;
    assign rs2_idx_o = insn.r.rs2;

    // ------------------------------------------------------------------------
    // opcode / funct decode
    // ------------------------------------------------------------------------
    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        supported = 1'b0;
        case (insn.r.opcode)
            OPC_OP_IMM: begin
                use_imm   = 1'b1;
                supported = 1'b1;
                case (insn.i.funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    F3_SLL: begin
                        alu_op    = ALU_SLL;
                        supported = (insn.r.funct7 == 7'b0);   // upper imm bits must be 0
                    end
                    default:    supported = 1'b0;              // shift right not built
                endcase
            end
            OPC_OP: begin
                if (insn.r.funct3 == F3_ADD_SUB) begin
                    if (insn.r.funct7 == 7'b0) begin
                        alu_op    = ALU_ADD;
                        supported = 1'b1;
                    end else if (insn.r.funct7 == F7_SUB) begin
                        alu_op    = ALU_SUB;
                        supported = 1'b1;
                    end
                end
            end
            default: supported = 1'b0;   // loads, stores, branches, lui, jal
        endcase
    end

    always_comb begin
        exec_d.valid  = fetch_i.valid & supported;
        exec_d.alu_op = alu_op;
        exec_d.op1    = rs1_data_i;
        exec_d.op2    = use_imm ? imm_sext : rs2_data_i;
        exec_d.rd     = insn.r.rd;
    end

    // ------------------------------------------------------------------------
    // decode to execute register
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clk_i) begin
        exec_r <= exec_d;
        if (!rst_n_i) begin
            exec_r.valid <= 1'b0;   // payload left as is
        end
    end

    assign exec_o = exec_r;

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`default_nettype none

module execute_stage
    import rv_pkg::*;
(
    input  wire exec_t exec_i,
    output wb_t        wb_o
);

    logic [XLEN-1:0] result;
    logic [4:0]      shamt;

    assign shamt = exec_i.op2[4:0];

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    always_comb begin
        case (exec_i.alu_op)
            ALU_ADD:  result = exec_i.op1 + exec_i.op2;
            ALU_SUB:  result = exec_i.op1 - exec_i.op2;   // rs1 - rs2
            ALU_SLT: begin
                result = ($signed(exec_i.op1) < $signed(exec_i.op2)) ?
                         XLEN'(1) : '0;
            end
            ALU_SLTU: result = (exec_i.op1 < exec_i.op2) ? XLEN'(1) : '0;
            ALU_XOR:  result = exec_i.op1 ^ exec_i.op2;
            ALU_OR:   result = exec_i.op1 | exec_i.op2;
            ALU_AND:  result = exec_i.op1 & exec_i.op2;
            ALU_SLL:  result = exec_i.op1 << shamt;
            default:  result = '0;
        endcase
    end

    // rd x0 still shows up here, reg_file drops it
    always_comb begin
        wb_o.wr_en = exec_i.valid;
        wb_o.rd    = exec_i.rd;
        wb_o.data  = result;
    end

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`default_nettype none

module fetch_unit
    import rv_pkg::*;
(
    input  wire logic                   sys_clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   run_i,
    input  wire logic [XLEN-1:0]        fetch_insn_i,   // word at fetch_idx_o
    output logic [IMEM_ADDR_W-1:0]      fetch_idx_o,
    output fetch_t                      fetch_o
);

    logic [IMEM_ADDR_W-1:0] pc_r;      // word index, not byte address
    fetch_t                 fetch_r;

    // ------------------------------------------------------------------------
    // program counter
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i || !run_i) begin
            pc_r <= '0;                                  // restart at word 0
        end else begin
            pc_r <= pc_r + IMEM_ADDR_W'(1);
        end
    end

    // ------------------------------------------------------------------------
    // fetch to decode register
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i || !run_i) begin
            fetch_r.valid <= 1'b0;
            fetch_r.insn  <= INSN_NOP;
        end else begin
            fetch_r.valid <= 1'b1;
            fetch_r.insn  <= fetch_insn_i;
        end
    end

    assign fetch_idx_o = pc_r;
    assign fetch_o     = fetch_r;

endmodule

`default_nettype wire

// File: src/instr_mem.sv
`default_nettype none

module instr_mem
    import rv_pkg::*;
(
    input  wire logic                   sys_clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   run_i,
    // program load port, four-phase req/ack
    input  wire logic                   load_req_i,
    input  wire load_t                  load_i,
    output logic                        load_ack_o,
    // fetch port
    input  wire logic [IMEM_ADDR_W-1:0] fetch_idx_i,
    output logic [XLEN-1:0]             fetch_insn_o
);

    logic [XLEN-1:0] mem [IMEM_WORDS];

    logic load_ack_r;
    logic fetch_grant;   // core running, fetch owns the array
    logic load_grant;    // one write per handshake

    // ------------------------------------------------------------------------
    // arbiter
    // ------------------------------------------------------------------------
    // the run flag decides the owner; a load request seen while running
    // just waits here without an ack
    assign fetch_grant = run_i;
    assign load_grant  = load_req_i & ~load_ack_r & ~fetch_grant;

    // ack state
    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            load_ack_r <= 1'b0;
        end else if (load_grant) begin
            load_ack_r <= 1'b1;          // word written this edge
        end else if (!load_req_i) begin
            load_ack_r <= 1'b0;          // requester let go, close the cycle
        end
    end

    // word array
    always_ff @(posedge sys_clk_i) begin
        if (load_grant) begin
            mem[load_i.idx] <= load_i.word;
        end
    end

    assign load_ack_o   = load_ack_r;
    assign fetch_insn_o = mem[fetch_idx_i];   // async read

endmodule

`default_nettype wire

// File: src/reg_file.sv
`default_nettype none

module reg_file
    import rv_pkg::*;
(
    input  wire logic                  sys_clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic [REG_ADDR_W-1:0] rs1_idx_i,
    input  wire logic [REG_ADDR_W-1:0] rs2_idx_i,
    output logic [XLEN-1:0]            rs1_data_o,
    output logic [XLEN-1:0]            rs2_data_o,
    input  wire wb_t                   wb_i
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];

    // x0 first, then same-cycle write-back, then the array
    function automatic logic [XLEN-1:0] read_port(
        input logic [REG_ADDR_W-1:0] idx,
        input wb_t                   wb,
        input logic [XLEN-1:0]       stored
    );
        if (idx == '0) begin
            return '0;
        end else if (wb.wr_en && wb.rd == idx) begin
            return wb.data;           // bypass
        end
        return stored;
    endfunction

    assign rs1_data_o = read_port(rs1_idx_i, wb_i, regs[rs1_idx_i]);
    assign rs2_data_o = read_port(rs2_idx_i, wb_i, regs[rs2_idx_i]);

    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wr_en && wb_i.rd != '0) begin   // x0 stays zero
            regs[wb_i.rd] <= wb_i.data;
        end
    end

endmodule

`default_nettype wire

// File: src/rv_core_top.sv
`default_nettype none

module rv_core_top
    import rv_pkg::*;
(
    input  wire logic  sys_clk_i,
    input  wire logic  rst_n_i,
    input  wire logic  run_i,
    // program load
    input  wire logic  load_req_i,
    input  wire load_t load_i,
    output logic       load_ack_o,
    // write-back, visible outside
    output wb_t        wb_o
);

    logic [IMEM_ADDR_W-1:0] fetch_idx;
    logic [XLEN-1:0]        fetch_insn;
    fetch_t                 fetch_rec;
    exec_t                  exec_rec;
    wb_t                    wb_rec;
    logic [REG_ADDR_W-1:0]  rs1_idx;
    logic [REG_ADDR_W-1:0]  rs2_idx;
    logic [XLEN-1:0]        rs1_data;
    logic [XLEN-1:0]        rs2_data;

    // ------------------------------------------------------------------------
    // instruction memory, shared by fetch and loader
    // ------------------------------------------------------------------------
    instr_mem instr_mem_i (
        .sys_clk_i    (sys_clk_i),
        .rst_n_i      (rst_n_i),
        .run_i        (run_i),
        .load_req_i   (load_req_i),
        .load_i       (load_i),
        .load_ack_o   (load_ack_o),
        .fetch_idx_i  (fetch_idx),
        .fetch_insn_o (fetch_insn)
    );

    // ------------------------------------------------------------------------
    // pipeline
    // ------------------------------------------------------------------------
    fetch_unit fetch_unit_i (
        .sys_clk_i    (sys_clk_i),
        .rst_n_i      (rst_n_i),
        .run_i        (run_i),
        .fetch_insn_i (fetch_insn),
        .fetch_idx_o  (fetch_idx),
        .fetch_o      (fetch_rec)
    );

    decode_stage decode_stage_i (
        .sys_clk_i  (sys_clk_i),
        .rst_n_i    (rst_n_i),
        .fetch_i    (fetch_rec),
        .rs1_idx_o  (rs1_idx),
        .rs2_idx_o  (rs2_idx),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .exec_o     (exec_rec)
    );

    reg_file reg_file_i (
        .sys_clk_i  (sys_clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_rec)
    );

    execute_stage execute_stage_i (
        .exec_i (exec_rec),
        .wb_o   (wb_rec)
    );

    assign wb_o = wb_rec;   // same record the reg file writes

endmodule

`default_nettype wire

// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ------------------------------------------------------------------------
    // widths and sizes
    // ------------------------------------------------------------------------
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_WORDS  = 4096;
    localparam int IMEM_ADDR_W = $clog2(IMEM_WORDS);   // 12

    // ------------------------------------------------------------------------
    // instruction encodings
    // ------------------------------------------------------------------------
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_OP     = 7'b011_0011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_SUB     = 7'b010_0000;

    localparam logic [XLEN-1:0] INSN_NOP = 32'h0000_0013;   // addi x0,x0,0

    // alu operation field
    localparam int ALU_OP_W = 4;
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd7;

    // ------------------------------------------------------------------------
    // instruction word, R and I views over the same 32 bits
    // ------------------------------------------------------------------------
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
    } insn_u;

    // pipeline records
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] insn;
    } fetch_t;

    typedef struct packed {
        logic                  valid;
        logic [ALU_OP_W-1:0]   alu_op;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [REG_ADDR_W-1:0] rd;
    } exec_t;

    typedef struct packed {
        logic                  wr_en;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic [IMEM_ADDR_W-1:0] idx;
        logic [XLEN-1:0]        word;
    } load_t;

endpackage

`default_nettype wire
